// File: verilog.f
src/spi_bus_pkg.sv
src/spi_map_pkg.sv
src/spi_sub_if.sv
src/spi_peripheral.sv
src/csr_block.sv
src/byte_buffer.sv
src/checksum_unit.sv
src/spi_subsystem_top.sv
tb/spi_subsystem_sva.sv
tb/spi_subsystem_tb.sv

// File: tb/spi_subsystem_vectors.txt
// columns: mode, address, byte count, then data bytes (modes 00 and 03), then expected (mode 00)
// modes: 00 file, 01 random data, 02 zero data checked by model, 03 abort, 04 reset, ff end
00 10 03  11 22 33  81 81 81        // chip id in every byte
00 45 02  aa 55  00 00              // unmapped address
00 11 01  5a  00                    // control write
00 11 01  c3  5a
00 11 01  c3  c3                    // last byte written kept
00 12 01  00  00                    // buffer still empty
01 20 0a                            // ten random bytes into the buffer
00 12 01  00  0a                    // status follows fill level
02 21 0c                            // bytes past the level read zero
01 20 12                            // eighteen bytes, two past the depth
02 21 12
00 12 01  00  10
00 32 01  00  00                    // clear checksum
00 30 04  12 34 56 78  00 00 00 00
00 31 02  00 00  14 08              // sum 0x114 wraps, xor
01 30 05                            // random bytes on top
02 31 03
03 11 01  ee                        // control write cut mid byte
00 11 01  c3  c3
03 20 01  77                        // buffer write cut mid byte
00 12 01  00  10
02 21 02
04 00 00                            // system reset
00 11 01  00  00
00 12 01  00  00
02 31 02
02 21 02
ff

// File: tb/spi_subsystem_tb.sv
// reads tb/spi_subsystem_vectors.txt from the project root; at most 32 data bytes per frame
`timescale 1ns/1ps

module spi_subsystem_tb;

    localparam int BUFFER_DEPTH = 16;
    localparam int MAX_BYTES    = 32;   // data bytes per frame
    localparam int VEC_SIZE     = 256;

    // register map of the sensor controller
    localparam logic [7:0] ADDR_CHIP_ID    = 8'h10;
    localparam logic [7:0] ADDR_CONTROL    = 8'h11;
    localparam logic [7:0] ADDR_STATUS     = 8'h12;
    localparam logic [7:0] ADDR_BUF_WRITE  = 8'h20;
    localparam logic [7:0] ADDR_BUF_READ   = 8'h21;
    localparam logic [7:0] ADDR_SUM_DATA   = 8'h30;
    localparam logic [7:0] ADDR_SUM_RESULT = 8'h31;
    localparam logic [7:0] ADDR_SUM_CLEAR  = 8'h32;

    // record kinds in the vector file
    localparam logic [7:0] MODE_FILE   = 8'h00;   // data and expected from file
    localparam logic [7:0] MODE_RANDOM = 8'h01;   // random data, expected from model
    localparam logic [7:0] MODE_MODEL  = 8'h02;   // zero data, expected from model
    localparam logic [7:0] MODE_ABORT  = 8'h03;   // last byte cut after four bits
    localparam logic [7:0] MODE_RESET  = 8'h04;
    localparam logic [7:0] END_MARK    = 8'hff;

    logic       spi_clock_in = 1'b0;
    logic       spi_resetn;
    logic       spi_select;
    logic       spi_data_in;
    logic       spi_data_out;

    logic [7:0] vec [0:VEC_SIZE-1];          // flat byte stream of all records
    logic [7:0] tx_bytes [0:MAX_BYTES-1];
    logic [7:0] rx_bytes [0:MAX_BYTES-1];
    logic [7:0] exp_bytes [0:MAX_BYTES-1];
    logic [7:0] buf_model [0:BUFFER_DEPTH-1];
    logic [7:0] ctrl_model;
    logic [7:0] sum_model;
    logic [7:0] xor_model;
    int         level_model;
    integer     seed;
    int         error_count = 0;
    int         check_count = 0;
    int         frame_total = 0;
    int         timeout_ns  = 0;
    int         sva_fails;
    int         frame;
    int         ptr;                        // read position in vec
    int         k;
    int         count;
    logic [7:0] mode;
    logic [7:0] addr;

    spi_subsystem_top #(
        .BUFFER_DEPTH (BUFFER_DEPTH)
    ) uut (
        .spi_resetn   (spi_resetn),
        .spi_select   (spi_select),
        .spi_clock_in (spi_clock_in),
        .spi_data_in  (spi_data_in),
        .spi_data_out (spi_data_out)
    );

    always #50 spi_clock_in = ~spi_clock_in;   // 100 ns period

    task automatic check_byte(input string name, input logic [7:0] expected,
                              input logic [7:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED %s expected %02h actual %02h", name, expected, actual);
        end
    endtask

    // count records and size the watchdog
    task automatic scan_vectors();
        int         pos;
        int         longest;
        logic [7:0] kind;
        pos     = 0;
        longest = 0;
        while (pos < VEC_SIZE - 3 && !$isunknown(vec[pos]) && vec[pos] != END_MARK) begin
            kind = vec[pos];
            if (kind > MODE_RESET || vec[pos + 2] > MAX_BYTES) begin
                $display("vector file has a bad record at byte %0d", pos);
                error_count++;
                break;
            end
            frame_total++;
            if (vec[pos + 2] > longest) longest = vec[pos + 2];
            if (kind == MODE_FILE) pos = pos + 3 + 2 * vec[pos + 2];
            else if (kind == MODE_ABORT) pos = pos + 3 + vec[pos + 2];
            else pos = pos + 3;
        end
        if (frame_total == 0) begin
            $display("no frames found in the vector file");
            error_count++;
        end
        timeout_ns = (frame_total * (8 * (longest + 1) + 16)) * 100 + 20000;   // plus margin
    endtask

    task automatic clear_model();
        ctrl_model  = 8'h00;
        sum_model   = 8'h00;
        xor_model   = 8'h00;
        level_model = 0;
    endtask

    // response the host should see for byte k, before this frame's writes
    function automatic logic [7:0] predict_response(input logic [7:0] at, input int idx);
        logic [7:0] value;
        value = 8'h00;   // unmapped or unaddressed
        case (at)
            ADDR_CHIP_ID:    value = 8'h81;
            ADDR_CONTROL:    value = ctrl_model;
            ADDR_STATUS:     value = (level_model > 255) ? 8'hff : 8'(level_model);
            ADDR_BUF_READ:   if (idx < level_model) value = buf_model[idx];
            ADDR_SUM_RESULT: begin
                if (idx == 0) value = sum_model;
                else if (idx == 1) value = xor_model;
            end
            default:         value = 8'h00;
        endcase
        return value;
    endfunction

    // fold a completed frame into the model
    task automatic update_model(input logic [7:0] at, input int len);
        int i;
        if (len > 0) begin
            case (at)
                ADDR_CONTROL: ctrl_model = tx_bytes[len - 1];   // last byte wins
                ADDR_BUF_WRITE: begin
                    for (i = 0; i < len && i < BUFFER_DEPTH; i++) buf_model[i] = tx_bytes[i];
                    level_model = (len > BUFFER_DEPTH) ? BUFFER_DEPTH : len;
                end
                ADDR_SUM_DATA: begin
                    for (i = 0; i < len; i++) begin
                        sum_model = sum_model + tx_bytes[i];
                        xor_model = xor_model ^ tx_bytes[i];
                    end
                end
                ADDR_SUM_CLEAR: begin
                    sum_model = 8'h00;
                    xor_model = 8'h00;
                end
                default: ;
            endcase
        end
    endtask

    // fill tx and expected bytes of the current record
    task automatic load_frame();
        int i;
        for (i = 0; i < count; i++) begin
            if (mode == MODE_RANDOM) begin
                tx_bytes[i] = 8'($random(seed));
            end else if (mode == MODE_MODEL) begin
                tx_bytes[i] = 8'h00;
            end else begin
                tx_bytes[i] = vec[ptr];
                ptr++;
            end
        end
        for (i = 0; i < count; i++) begin
            if (mode == MODE_FILE) begin
                exp_bytes[i] = vec[ptr];
                ptr++;
            end else begin
                exp_bytes[i] = predict_response(addr, i);
            end
        end
    endtask

    // one frame, MSB first; dout is taken on the edge where the dut takes the bit
    task automatic send_frame(input logic [7:0] at, input int len, input bit abort);
        int nbits;
        int j;
        int m;
        nbits = abort ? 8 * len + 4 : 8 * (len + 1);
        for (j = 0; j <= nbits; j++) begin
            @(posedge spi_clock_in);
            if (j > 8) begin
                m = j - 9;   // data bit sampled on this edge
                rx_bytes[m / 8][7 - (m % 8)] = spi_data_out;
            end
            if (j < nbits) begin
                spi_select <= 1'b0;
                if (j < 8) spi_data_in <= at[7 - j];
                else spi_data_in <= tx_bytes[(j - 8) / 8][7 - ((j - 8) % 8)];
            end
        end
        if (!abort) begin
            @(posedge spi_clock_in);   // wr_en of last byte lands here
        end
        spi_select  <= 1'b1;
        spi_data_in <= 1'b0;
        @(posedge spi_clock_in);       // next frame start makes two idle cycles
    endtask

    task automatic apply_reset();
        @(posedge spi_clock_in);
        spi_resetn <= 1'b0;
        repeat (10) @(posedge spi_clock_in);
        spi_resetn <= 1'b1;
        repeat (2) @(posedge spi_clock_in);
    endtask

    initial begin
        spi_resetn  = 1'b0;
        spi_select  = 1'b1;
        spi_data_in = 1'b0;
        seed        = 32'h6290a302;
        clear_model();
        $readmemh("tb/spi_subsystem_vectors.txt", vec);
        scan_vectors();
        repeat (10) @(posedge spi_clock_in);
        spi_resetn <= 1'b1;
        repeat (2) @(posedge spi_clock_in);
        ptr = 0;
        for (frame = 0; frame < frame_total; frame++) begin
            mode  = vec[ptr];
            addr  = vec[ptr + 1];
            count = vec[ptr + 2];
            ptr   = ptr + 3;
            if (mode == MODE_RESET) begin
                apply_reset();
                clear_model();   // blocks back to zero
            end else begin
                load_frame();
                send_frame(addr, count, mode == MODE_ABORT);
                if (mode != MODE_ABORT) begin
                    for (k = 0; k < count; k++) begin
                        check_byte($sformatf("frame %0d addr %02h byte %0d", frame, addr, k),
                                   exp_bytes[k], rx_bytes[k]);
                    end
                    update_model(addr, count);
                end
            end
        end
        sva_fails = uut.u_spi_peripheral.u_sva.fail_count;
        $display("errors %0d in %0d checks, assertion failures %0d",
                 error_count, check_count, sva_fails);
        if (error_count == 0 && sva_fails == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // watchdog armed once the vectors are scanned
    initial begin
        wait (timeout_ns > 0);
        #(timeout_ns);
        $display("timeout after %0d ns, frames did not complete", timeout_ns);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: tb/spi_subsystem_sva.sv
// bound into spi_peripheral; checks are sampled on the spi clock and off while in system reset
`timescale 1ns/1ps

module spi_subsystem_sva (
    input logic spi_clock_in,
    input logic spi_resetn,
    input logic spi_select,      // active low
    input logic address_valid,
    input logic rd_en,
    input logic wr_en
);

    int fail_count = 0;   // failed assertion count for the testbench

    // address strobe never overlaps the data strobes
    strobe_exclusive: assert property (
        @(posedge spi_clock_in) disable iff (!spi_resetn)
        !(address_valid && (rd_en || wr_en))
    ) else begin
        fail_count++;
        $error("address_valid high together with rd_en or wr_en");
    end

    // read strobe always followed by the write strobe of the same byte
    read_then_write: assert property (
        @(posedge spi_clock_in) disable iff (!spi_resetn || spi_select)
        rd_en |=> wr_en
    ) else begin
        fail_count++;
        $error("rd_en not followed by wr_en in the next cycle");
    end

    // deselect holds the target in frame reset
    quiet_when_idle: assert property (
        @(posedge spi_clock_in) disable iff (!spi_resetn)
        spi_select |-> !(address_valid || rd_en || wr_en)
    ) else begin
        fail_count++;
        $error("strobe high while spi_select is high");
    end

endmodule

bind spi_peripheral spi_subsystem_sva u_sva (
    .spi_clock_in  (spi_clock_in),
    .spi_resetn    (spi_resetn),
    .spi_select    (spi_select),
    .address_valid (bus.address_valid),
    .rd_en         (bus.rd_en),
    .wr_en         (bus.wr_en)
);

// File: src/spi_subsystem_top.sv
// single spi clock domain with no system clock; select is active low and BUFFER_DEPTH >= 2
`timescale 1ns/1ps

module spi_subsystem_top #(
    parameter int BUFFER_DEPTH = 16
) (
    input  logic spi_resetn,
    input  logic spi_select,
    input  logic spi_clock_in,
    input  logic spi_data_in,
    output logic spi_data_out
);

    spi_bus_pkg::bus_data_t   response_csr;
    spi_bus_pkg::bus_data_t   response_buffer;
    spi_bus_pkg::bus_data_t   response_checksum;
    spi_bus_pkg::byte_count_t fill_level;   // buffer level into status

    spi_sub_if sub_bus ();   // command strobes to all blocks

    spi_peripheral u_spi_peripheral (
        .spi_resetn        (spi_resetn),
        .spi_select        (spi_select),
        .spi_clock_in      (spi_clock_in),
        .spi_data_in       (spi_data_in),
        .spi_data_out      (spi_data_out),
        .bus               (sub_bus.host),
        .response_csr      (response_csr),
        .response_buffer   (response_buffer),
        .response_checksum (response_checksum)
    );

    // register blocks reset by system reset only
    csr_block u_csr_block (
        .spi_clock_in (spi_clock_in),
        .spi_resetn   (spi_resetn),
        .bus          (sub_bus.sub),
        .fill_level   (fill_level),
        .response     (response_csr)
    );

    byte_buffer #(
        .BUFFER_DEPTH (BUFFER_DEPTH)
    ) u_byte_buffer (
        .spi_clock_in (spi_clock_in),
        .spi_resetn   (spi_resetn),
        .bus          (sub_bus.sub),
        .fill_level   (fill_level),
        .response     (response_buffer)
    );

    checksum_unit u_checksum_unit (
        .spi_clock_in (spi_clock_in),
        .spi_resetn   (spi_resetn),
        .bus          (sub_bus.sub),
        .response     (response_checksum)
    );

endmodule

// File: src/checksum_unit.sv
// sum is modulo 256; both accumulators survive deselect and clear on reset or ADDR_SUM_CLEAR
`timescale 1ns/1ps

module checksum_unit (
    input  logic                   spi_clock_in,
    input  logic                   spi_resetn,
    spi_sub_if.sub                 bus,
    output spi_bus_pkg::bus_data_t response
);

    spi_bus_pkg::bus_data_t sum_acc;   // wraps at 256
    spi_bus_pkg::bus_data_t xor_acc;
    logic                   sum_wr;
    logic                   clr_wr;

    assign sum_wr = bus.wr_en && (bus.address == spi_map_pkg::ADDR_SUM_DATA);
    assign clr_wr = bus.wr_en && (bus.address == spi_map_pkg::ADDR_SUM_CLEAR);  // data ignored

    always_ff @(posedge spi_clock_in or negedge spi_resetn) begin
        if (!spi_resetn) begin
            sum_acc <= '0;
            xor_acc <= '0;
        end else if (clr_wr) begin
            sum_acc <= '0;
            xor_acc <= '0;
        end else if (sum_wr) begin
            sum_acc <= sum_acc + bus.wr_data;   // carry dropped
            xor_acc <= xor_acc ^ bus.wr_data;
        end
    end

    // result frame returns sum then xor
    always_comb begin
        response = '0;
        if (bus.address == spi_map_pkg::ADDR_SUM_RESULT) begin
            if (bus.rd_byte_count == 0) begin
                response = sum_acc;
            end else if (bus.rd_byte_count == 1) begin
                response = xor_acc;
            end
            // later bytes read zero
        end
    end

endmodule

// File: src/byte_buffer.sv
// BUFFER_DEPTH must be at least 2; bytes past the depth are dropped and each write sets the level
`timescale 1ns/1ps

module byte_buffer #(
    parameter int BUFFER_DEPTH = 16
) (
    input  logic                     spi_clock_in,
    input  logic                     spi_resetn,
    spi_sub_if.sub                   bus,
    output spi_bus_pkg::byte_count_t fill_level,   // to csr status
    output spi_bus_pkg::bus_data_t   response
);

    localparam int INDEX_WIDTH = $clog2(BUFFER_DEPTH);
    localparam spi_bus_pkg::byte_count_t DEPTH = BUFFER_DEPTH;   // for index compares

    spi_bus_pkg::bus_data_t   mem [BUFFER_DEPTH];   // no reset, level guards reads
    logic                     buf_wr;              // write strobe for this block
    logic                     in_range;            // write index fits the memory
    logic                     rd_hit;              // read index below the level
    logic [INDEX_WIDTH-1:0]   wr_index;
    logic [INDEX_WIDTH-1:0]   rd_index;

    assign buf_wr   = bus.wr_en && (bus.address == spi_map_pkg::ADDR_BUF_WRITE);
    assign in_range = bus.wr_byte_count < DEPTH;
    assign rd_hit   = bus.rd_byte_count < fill_level;   // level never above DEPTH
    assign wr_index = bus.wr_byte_count[INDEX_WIDTH-1:0];
    assign rd_index = bus.rd_byte_count[INDEX_WIDTH-1:0];

    // storage
    always_ff @(posedge spi_clock_in) begin
        if (buf_wr && in_range) begin
            mem[wr_index] <= bus.wr_data;
        end
    end

    // fill level tracks the stream just written
    // so a shorter stream shortens it again
    always_ff @(posedge spi_clock_in or negedge spi_resetn) begin
        if (!spi_resetn) begin
            fill_level <= '0;
        end else if (buf_wr) begin
            if (in_range) begin
                fill_level <= bus.wr_byte_count + 1'b1;
            end else begin
                fill_level <= DEPTH;   // overflow bytes dropped
            end
        end
    end

    // replay by byte index of the read frame
    always_comb begin
        if ((bus.address == spi_map_pkg::ADDR_BUF_READ) && rd_hit) begin
            response = mem[rd_index];
        end else begin
            response = '0;   // other address or past the level
        end
    end

endmodule

// File: src/csr_block.sv
// control register survives deselect and clears only on system reset; status saturates at 255
`timescale 1ns/1ps

module csr_block (
    input  logic                     spi_clock_in,
    input  logic                     spi_resetn,
    spi_sub_if.sub                   bus,
    input  spi_bus_pkg::byte_count_t fill_level,   // from byte_buffer
    output spi_bus_pkg::bus_data_t   response
);

    localparam spi_bus_pkg::byte_count_t STATUS_MAX = 255;   // largest level in one byte

    spi_bus_pkg::bus_data_t control;   // host owned byte
    spi_bus_pkg::bus_data_t status;    // clamped fill level
    logic                   control_wr;

    assign control_wr = bus.wr_en && (bus.address == spi_map_pkg::ADDR_CONTROL);

    // fill level does not fit a byte beyond 255
    always_comb begin
        if (fill_level > STATUS_MAX) begin
            status = '1;
        end else begin
            status = spi_bus_pkg::bus_data_t'(fill_level);
        end
    end

    // every data byte of a control frame overwrites it
    // last byte wins
    always_ff @(posedge spi_clock_in or negedge spi_resetn) begin
        if (!spi_resetn) begin
            control <= '0;
        end else if (control_wr) begin
            control <= bus.wr_data;
        end
    end

    // own addresses only
    // zero elsewhere for the OR merge
    always_comb begin
        case (bus.address)
            spi_map_pkg::ADDR_CHIP_ID: begin
                response = spi_map_pkg::CHIP_ID;   // same in every byte
            end
            spi_map_pkg::ADDR_CONTROL: begin
                response = control;                // value before this byte's write
            end
            spi_map_pkg::ADDR_STATUS: begin
                response = status;
            end
            default: begin
                response = '0;
            end
        endcase
    end

endmodule

// File: src/spi_peripheral.sv
// spi mode 0 target only; select is active low and a deselect mid-byte drops that byte
`timescale 1ns/1ps

module spi_peripheral (
    input  logic                   spi_resetn,
    input  logic                   spi_select,        // active low
    input  logic                   spi_clock_in,
    input  logic                   spi_data_in,
    output logic                   spi_data_out,
    spi_sub_if.host                bus,
    input  spi_bus_pkg::bus_data_t response_csr,
    input  spi_bus_pkg::bus_data_t response_buffer,
    input  spi_bus_pkg::bus_data_t response_checksum
);

    typedef enum logic {
        PHASE_ADDR,    // first byte of the frame
        PHASE_DATA     // repeating data bytes
    } frame_phase_t;

    logic                   frame_resetn;   // system reset or deselect
    frame_phase_t           phase;
    logic [2:0]             bit_count;      // bits left in the byte minus one
    spi_bus_pkg::bus_data_t shift_reg;      // response out and data in share it
    spi_bus_pkg::bus_data_t response;       // merged block responses

    assign frame_resetn = spi_resetn & ~spi_select;
    assign response     = response_csr | response_buffer | response_checksum;  // unaddressed = 0
    assign bus.wr_data  = shift_reg;

    // bit and byte tracking plus strobes
    always_ff @(posedge spi_clock_in or negedge frame_resetn) begin
        if (!frame_resetn) begin
            phase             <= PHASE_ADDR;
            bit_count         <= 3'd7;
            bus.address_valid <= 1'b0;
            bus.rd_en         <= 1'b0;
            bus.wr_en         <= 1'b0;
            bus.rd_byte_count <= '0;
            bus.wr_byte_count <= '0;
        end else begin
            bit_count <= bit_count - 3'd1;   // wraps back to 7 after bit 0
            if (bit_count == 3'd0) begin
                phase <= PHASE_DATA;          // stays in data until deselect
                if (phase == PHASE_DATA) begin
                    bus.rd_byte_count <= bus.rd_byte_count + 1'b1;  // next byte to send
                end
            end
            bus.address_valid <= (phase == PHASE_ADDR) && (bit_count == 3'd0);
            bus.rd_en         <= (phase == PHASE_DATA) && (bit_count == 3'd1);
            bus.wr_en         <= (phase == PHASE_DATA) && (bit_count == 3'd0);
            // catch up once the write strobe has been seen
            if (bus.wr_en) begin
                bus.wr_byte_count <= bus.rd_byte_count;
            end
        end
    end

    // sample host data MSB first
    always_ff @(posedge spi_clock_in) begin
        if (phase == PHASE_ADDR) begin
            bus.address <= {bus.address[6:0], spi_data_in};
        end else if (bit_count == 3'd7) begin
            // first bit of a data byte loads the response behind it
            shift_reg <= {response[6:0], spi_data_in};
        end else begin
            shift_reg <= {shift_reg[6:0], spi_data_in};
        end
    end

    // drive response half a clock ahead of the host sample
    always_ff @(negedge spi_clock_in or negedge frame_resetn) begin
        if (!frame_resetn) begin
            spi_data_out <= 1'b0;
        end else if (phase == PHASE_DATA) begin
            if (bit_count == 3'd7) begin
                spi_data_out <= response[7];     // msb straight from the merge
            end else begin
                spi_data_out <= shift_reg[7];    // rest from the loaded register
            end
        end
    end

endmodule

// File: src/spi_sub_if.sv
// one host only; strobes are one spi clock wide and exist only while the device is selected
`timescale 1ns/1ps

interface spi_sub_if;

    spi_bus_pkg::bus_addr_t   address;         // shifted in during the address phase
    logic                     address_valid;   // one cycle after the 8th rising edge
    spi_bus_pkg::bus_data_t   wr_data;         // last complete data byte
    spi_bus_pkg::byte_count_t rd_byte_count;   // index of byte being shifted out
    spi_bus_pkg::byte_count_t wr_byte_count;   // index of wr_data while wr_en is high
    logic                     rd_en;           // one cycle before last bit edge
    logic                     wr_en;           // cycle after last bit edge

    // spi target drives the command side
    modport host (
        output address,
        output address_valid,
        output wr_data,
        output rd_byte_count,
        output wr_byte_count,
        output rd_en,
        output wr_en
    );

    // register blocks only listen
    modport sub (
        input address,
        input address_valid,
        input wr_data,
        input rd_byte_count,
        input wr_byte_count,
        input rd_en,
        input wr_en
    );

endinterface

// File: src/spi_map_pkg.sv
// address map assumes one address byte per frame and blocks that decode their own range
package spi_map_pkg;

    // csr block 0x10..0x12
    localparam spi_bus_pkg::bus_addr_t ADDR_CHIP_ID    = 8'h10;  // identity in every byte
    localparam spi_bus_pkg::bus_addr_t ADDR_CONTROL    = 8'h11;  // r/w control byte
    localparam spi_bus_pkg::bus_addr_t ADDR_STATUS     = 8'h12;  // buffer fill level

    // byte buffer 0x20..0x21
    localparam spi_bus_pkg::bus_addr_t ADDR_BUF_WRITE  = 8'h20;  // stream in from index 0
    localparam spi_bus_pkg::bus_addr_t ADDR_BUF_READ   = 8'h21;  // byte k returns entry k

    // checksum unit 0x30..0x32
    localparam spi_bus_pkg::bus_addr_t ADDR_SUM_DATA   = 8'h30;  // bytes to accumulate
    localparam spi_bus_pkg::bus_addr_t ADDR_SUM_RESULT = 8'h31;  // byte 0 sum then byte 1 xor
    localparam spi_bus_pkg::bus_addr_t ADDR_SUM_CLEAR  = 8'h32;  // any write clears both

    // identity byte returned at ADDR_CHIP_ID
    localparam spi_bus_pkg::bus_data_t CHIP_ID         = 8'h81;

    // everything else in the map reads back as zero

endpackage

// File: src/spi_bus_pkg.sv
// byte lanes fixed at 8 bits and the in-frame byte index wraps after 2^32 bytes
package spi_bus_pkg;

    // widths of the command path between the spi target and its blocks
    localparam int ADDR_WIDTH  = 8;    // first byte of every frame
    localparam int DATA_WIDTH  = 8;    // one data or response byte
    localparam int COUNT_WIDTH = 32;   // data byte index inside a frame

    // register address taken from the address phase
    typedef logic [ADDR_WIDTH-1:0] bus_addr_t;

    // payload byte in either direction
    // blocks drive zero when not addressed so responses can be ORed
    typedef logic [DATA_WIDTH-1:0] bus_data_t;

    // counts data bytes from 0
    // restarts with every new frame
    typedef logic [COUNT_WIDTH-1:0] byte_count_t;

endpackage
